// File: flist.f
common/comm_cmd_pkg.sv
common/comm_link_pkg.sv
nibble_ctrl/nibble_ctrl.sv
uart/uart_link.sv
spi/spi_master.sv
hdl/comm_ic.sv
verif/clk_gen.sv
verif/tb_comm_ic.sv

// File: run.sh
#!/bin/sh
# Compile and run the comm_ic testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_comm_ic -o tb_comm_ic; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tb_comm_ic)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^SIMULATION PASSED$'; then
	exit 0
fi
echo "Pass message not found"
exit 1

// File: verif/tb_comm_ic.sv
// Testbench for the serial bus bridge
// Host nibble writes and reads, UART and SPI loopback in every mode,
// a bad-parity frame and a write dropped while the link is busy

`timescale 1ns/1ps

module tb_comm_ic;
	import comm_cmd_pkg::*;
	import comm_link_pkg::*;

	localparam int UART_WORST      = 11 * 35;		// 11 bits, div up to 34
	localparam int SPI_WORST       = 33 * 16;		// 32 edges plus tail, div up to 15
	localparam int N_TESTS         = 6;
	localparam int TEST_WORST      = 8 * SPI_WORST;	// Longest test, all SPI modes
	localparam int WATCHDOG_CYCLES = N_TESTS * TEST_WORST + 1000;
	// Longest single frame or transfer
	localparam int WAIT_LIMIT      = ((SPI_WORST > UART_WORST) ? SPI_WORST : UART_WORST) + 64;

	// Status outputs that wait_level can follow
	localparam int S_NEW   = 0;
	localparam int S_UBUSY = 1;
	localparam int S_SBUSY = 2;
	localparam int S_UERR  = 3;

	logic			clk;
	logic			reset_n;
	logic [3:0]		data_in;
	logic			data_en;
	logic [3:0]		data_out;
	logic [3:0]		data_op_en;
	logic			uart_rx;
	logic			uart_tx;
	logic			sen;
	logic			sclk;
	logic			mosi;
	logic			new_uart;
	logic			busy_uart;
	logic			busy_spi;
	logic			uart_error;

	// Expectations and check windows
	logic			drive_rx;		// Testbench owns the UART line
	logic			rx_level;
	int				rd_idx;			// Read nibble due at the next edge, 0 when idle
	int				rd_len;
	logic [15:0]	exp_word;
	logic [3:0]		exp_nib;
	logic			no_new;			// new_uart must stay low
	logic			err_hold;		// uart_error must be high
	logic			rst_seen;
	logic			spi_wide;		// Stored SPI width
	logic			spi_pol;		// Stored SPI clock polarity
	logic [31:0]	lfsr_state = 32'h1fda5983;
	int				errors = 0;
	int				errors_before = 0;
	int				test_no = 0;

	////////////////////
	// DUT and loopback
	////////////////////
	clk_gen u_clk (.clk(clk), .reset_n(reset_n));

	assign uart_rx = drive_rx ? rx_level : uart_tx;	// Loopback unless tb drives a frame
	assign exp_nib = 4'(exp_word >> (4 * (rd_len - rd_idx)));	// MSB nibble first

	comm_ic DUT (
		.clk(clk), .reset_n(reset_n),
		.data_in(data_in), .data_en(data_en),
		.data_out(data_out), .data_op_en(data_op_en),
		.UART_RX(uart_rx), .UART_TX(uart_tx),
		.SEN(sen), .SCLK(sclk), .MOSI(mosi), .MISO(mosi),	// SPI loopback
		.new_uart(new_uart), .busy_uart(busy_uart),
		.busy_spi(busy_spi), .uart_error(uart_error)
	);

	always @(posedge clk)
		rst_seen <= !reset_n;	// Skip the first reset edge, registers still unknown

	function void note_mismatch(input string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endfunction

	function void note_failure(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endfunction

	////////////////////
	// Checks
	////////////////////
	a_reset_state: assert property (@(posedge clk) (!reset_n && rst_seen) |->
		(data_op_en == 4'h0 && sen && !sclk && uart_tx && !busy_uart && !busy_spi
		&& !new_uart && !uart_error))
		else note_mismatch("outputs off their reset values during reset");

	a_read_nibble: assert property (@(posedge clk) disable iff (!reset_n)
		rd_idx != 0 |-> data_out == exp_nib)
		else note_mismatch($sformatf("read nibble %0d is %h, expected %h",
			$sampled(rd_idx), $sampled(data_out), $sampled(exp_nib)));

	// Pads driven exactly during read-back nibbles
	a_op_en_window: assert property (@(posedge clk) disable iff (!reset_n)
		data_op_en == ((rd_idx != 0) ? 4'hF : 4'h0))
		else note_mismatch($sformatf("data_op_en is %b with read nibble index %0d",
			$sampled(data_op_en), $sampled(rd_idx)));

	a_no_new: assert property (@(posedge clk) disable iff (!reset_n)
		no_new |-> !new_uart)
		else note_mismatch("new_uart high where no good frame is pending");

	a_parity_err: assert property (@(posedge clk) disable iff (!reset_n)
		err_hold |-> uart_error && !new_uart)
		else note_mismatch("bad parity frame not flagged by uart_error");

	a_sen_busy: assert property (@(posedge clk) disable iff (!reset_n)
		busy_spi |-> !sen)
		else note_mismatch("SEN high during an SPI transfer");

	// SCLK rests at CPOL where a transfer starts and ends
	a_sclk_rest: assert property (@(posedge clk) disable iff (!reset_n)
		($rose(busy_spi) || $fell(busy_spi)) |-> sclk == spi_pol)
		else note_mismatch($sformatf("SCLK is %b at a transfer boundary, CPOL %b",
			$sampled(sclk), $sampled(spi_pol)));

	////////////////////
	// Random source
	////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32, 22, 2, 1
	endfunction

	// One LFSR step per bit
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [3:0] uart_flags(input logic en, input logic send,
			input logic pe, input logic po);
		logic [3:0] f;
		f = 4'h0;
		f[UART_EN_BIT]      = en;
		f[UART_SEND_BIT]    = send;
		f[UART_PAR_EN_BIT]  = pe;
		f[UART_PAR_ODD_BIT] = po;
		return f;
	endfunction

	function automatic logic [3:0] spi_flags(input logic pol, input logic pha,
			input logic wide, input logic go);
		logic [3:0] f;
		f = 4'h0;
		f[SPI_CPOL_BIT]   = pol;
		f[SPI_CPHA_BIT]   = pha;
		f[SPI_BITS16_BIT] = wide;
		f[SPI_START_BIT]  = go;
		return f;
	endfunction

	function automatic logic status_bit(input int sel);
		case (sel)
			S_NEW:   return new_uart;
			S_UBUSY: return busy_uart;
			S_SBUSY: return busy_spi;
			default: return uart_error;
		endcase
	endfunction

	////////////////////
	// Host port tasks
	////////////////////
	task automatic put_nibble(input logic [3:0] nib);
		@(posedge clk);
		data_en <= 1'b1;
		data_in <= nib;
	endtask

	task automatic write_cmd(input logic [3:0] cmd, input logic cfg, input logic [7:0] div,
			input logic [3:0] flags, input logic [15:0] word, input int n_pay);
		put_nibble(cmd);
		if (cfg) begin
			put_nibble(div[7:4]);	// Divider high first
			put_nibble(div[3:0]);
			put_nibble(flags);
		end
		for (int i = n_pay; i > 0; i--)
			put_nibble(word[4*i-1 -: 4]);
		@(posedge clk);
		data_en <= 1'b0;	// Last nibble sampled here
	endtask

	task automatic read_word(input logic [3:0] cmd, input logic [15:0] word, input int n);
		put_nibble(cmd);
		@(posedge clk);		// Command edge
		data_en  <= 1'b0;
		exp_word <= word;
		rd_len   <= n;
		for (int i = 1; i <= n; i++) begin
			@(posedge clk);
			rd_idx <= i;	// Checked one edge later
		end
		@(posedge clk);
		rd_idx <= 0;
	endtask

	// Polls at the falling edge, away from DUT updates
	task automatic wait_level(input int sel, input logic lvl, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (status_bit(sel) != lvl && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (status_bit(sel) != lvl)
			note_failure($sformatf("timed out after %0d cycles waiting for %s", n, what));
	endtask

	task automatic quiet_check();
		repeat (2) @(posedge clk);	// rx_ack lands after the read
		no_new <= 1'b1;
		repeat (4) @(posedge clk);
		no_new <= 1'b0;
	endtask

	// Start, data LSB first, parity, stop
	task automatic drive_frame(input logic [7:0] b, input logic par, input int per);
		logic [10:0] frame;
		frame = {1'b1, par, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			rx_level <= frame[i];
			repeat (per - 1) @(posedge clk);
		end
	endtask

	task automatic uart_round(input logic [3:0] cmd, input logic cfg, input logic [7:0] div,
			input logic [3:0] flags, input logic [7:0] b);
		write_cmd(cmd, cfg, div, flags, {8'h00, b}, UART_NIBBLES);
		wait_level(S_NEW, 1'b1, "new_uart after the frame");
		wait_level(S_UBUSY, 1'b0, "end of the UART stop bit");
		read_word({CMD_READ, LINK_UART}, {8'h00, b}, UART_NIBBLES);
		quiet_check();
	endtask

	task automatic spi_round(input logic [3:0] cmd, input logic cfg, input logic [7:0] div,
			input logic [3:0] flags, input logic [15:0] word);
		int n;
		n = spi_wide ? SPI16_NIBBLES : SPI8_NIBBLES;
		write_cmd(cmd, cfg, div, flags, word, n);
		wait_level(S_SBUSY, 1'b1, "SPI busy rising");
		wait_level(S_SBUSY, 1'b0, "SPI busy falling");
		read_word({CMD_READ, LINK_SPI}, word, n);
	endtask

	task automatic test_done(input string name);
		test_no++;
		$display("test %0d (%s) done, %0d failed checks", test_no, name,
			errors - errors_before);
		errors_before = errors;
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		logic [7:0]		div;
		logic [7:0]		b;
		logic [15:0]	word;
		logic			po;

		data_en  <= 1'b0;
		data_in  <= 4'h0;
		drive_rx <= 1'b1;	// Line idle high until the link leaves reset
		rx_level <= 1'b1;
		rd_idx   <= 0;
		rd_len   <= 0;
		exp_word <= 16'h0000;
		no_new   <= 1'b0;
		err_hold <= 1'b0;
		spi_wide = 1'b0;
		spi_pol  = 1'b0;

		wait (reset_n);
		@(posedge clk);
		drive_rx <= 1'b0;
		test_done("reset state");

		div = 8'd3 + 8'(take_bits(5));
		uart_round({CMD_WRITE_NEW, LINK_UART}, 1'b1, div,
			uart_flags(1'b1, 1'b1, 1'(take_bits(1)), 1'(take_bits(1))), 8'(take_bits(8)));
		test_done("UART loopback");

		// Settings only, then a frame with the wrong parity bit
		div = 8'd3 + 8'(take_bits(5));
		po  = 1'(take_bits(1));
		b   = 8'(take_bits(8));
		write_cmd({CMD_WRITE_NEW, LINK_UART}, 1'b1, div,
			uart_flags(1'b1, 1'b0, 1'b1, po), 16'h0000, 0);
		@(posedge clk);
		drive_rx <= 1'b1;
		no_new   <= 1'b1;
		drive_frame(b, ~(^b ^ po), int'(div) + 1);
		wait_level(S_UERR, 1'b1, "uart_error after the bad parity frame");
		@(posedge clk);
		err_hold <= 1'b1;
		repeat (4) @(posedge clk);
		err_hold <= 1'b0;
		no_new   <= 1'b0;
		drive_rx <= 1'b0;
		test_done("UART parity error");

		for (int m = 0; m < 4; m++) begin
			for (int w = 0; w < 2; w++) begin
				div  = 8'(take_bits(3));
				word = take_bits(16);
				if (w == 0)
					word[15:8] = 8'h00;	// 8-bit word in the low byte
				spi_wide = w[0];
				spi_pol  = m[1];
				spi_round({CMD_WRITE_NEW, LINK_SPI}, 1'b1, div,
					spi_flags(m[1], m[0], w[0], 1'b1), word);
			end
		end
		test_done("SPI loopback, all modes and widths");

		// Stored settings from the runs above
		uart_round({CMD_WRITE_OLD, LINK_UART}, 1'b0, 8'h00, 4'h0, 8'(take_bits(8)));
		word = take_bits(16);
		if (!spi_wide)
			word[15:8] = 8'h00;
		spi_round({CMD_WRITE_OLD, LINK_SPI}, 1'b0, 8'h00, 4'h0, word);
		test_done("old settings writes");

		// Second word arrives mid-transfer and must be dropped
		div      = 8'd8 + 8'(take_bits(3));
		word     = take_bits(16);
		spi_wide = 1'b1;
		spi_pol  = 1'(take_bits(1));
		write_cmd({CMD_WRITE_NEW, LINK_SPI}, 1'b1, div,
			spi_flags(spi_pol, 1'(take_bits(1)), 1'b1, 1'b1), word, SPI16_NIBBLES);
		wait_level(S_SBUSY, 1'b1, "SPI busy rising");
		write_cmd({CMD_WRITE_OLD, LINK_SPI}, 1'b0, 8'h00, 4'h0, ~word, SPI16_NIBBLES);
		wait_level(S_SBUSY, 1'b0, "SPI busy falling");
		repeat (4) @(posedge clk);
		read_word({CMD_READ, LINK_SPI}, word, SPI16_NIBBLES);
		test_done("write dropped while busy");

		repeat (2) @(posedge clk);
		$display("%0d tests run, %0d failed checks in total", test_no, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verif/clk_gen.sv
// Testbench clock and reset source
// 8 ns clock, synchronous active-low reset held for the first 5 rising edges

`timescale 1ns/1ps

module clk_gen (
	output logic	clk,
	output logic	reset_n
);
	localparam int PERIOD_NS    = 8;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset_n <= 1'b0;	// In reset from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule

// File: hdl/comm_ic.sv
// Serial bus bridge top
// Host nibble port in front of a UART link and an SPI master
// No I2C pins on this tile

`timescale 1ns/1ps

module comm_ic (
	input  logic		clk,
	input  logic		reset_n,
	// Host nibble port
	input  logic [3:0]	data_in,
	input  logic		data_en,
	output logic [3:0]	data_out,
	output logic [3:0]	data_op_en,	// Pad direction, all ones while driving
	// UART pins
	input  logic		UART_RX,
	output logic		UART_TX,
	// SPI pins
	output logic		SEN,		// Active low select
	output logic		SCLK,
	output logic		MOSI,
	input  logic		MISO,
	// Status to host
	output logic		new_uart,
	output logic		busy_uart,
	output logic		busy_spi,
	output logic		uart_error
);
	import comm_link_pkg::*;

	// UART side
	logic				uart_enable;
	logic [DIV_W-1:0]	uart_div;
	logic				parity_en;
	logic				parity_odd;
	logic				tx_start;
	logic [UART_W-1:0]	tx_data;
	logic [UART_W-1:0]	rx_data;
	logic				rx_new;
	logic				rx_ack;

	// SPI side
	logic [DIV_W-1:0]	spi_div;
	logic				cpol;
	logic				cpha;
	logic				bits16;
	logic				spi_start;
	logic [SPI_W-1:0]	spi_wdata;
	logic [SPI_W-1:0]	spi_rdata;

	nibble_ctrl u_ctrl (
		.clk(clk), .reset_n(reset_n),
		.data_in(data_in), .data_en(data_en),
		.data_out(data_out), .data_op_en(data_op_en),
		.uart_enable(uart_enable), .uart_div(uart_div),
		.parity_en(parity_en), .parity_odd(parity_odd),
		.tx_start(tx_start), .tx_data(tx_data),
		.rx_data(rx_data), .rx_new(rx_new), .rx_error(uart_error),
		.rx_ack(rx_ack), .new_uart(new_uart),
		.spi_div(spi_div), .cpol(cpol), .cpha(cpha), .bits16(bits16),
		.spi_start(spi_start), .spi_wdata(spi_wdata), .spi_rdata(spi_rdata)
	);

	uart_link u_uart (
		.clk(clk), .reset_n(reset_n),
		.enable(uart_enable), .div(uart_div),
		.parity_en(parity_en), .parity_odd(parity_odd),
		.tx_start(tx_start), .tx_data(tx_data), .tx_busy(busy_uart),
		.rx_ack(rx_ack), .rx_data(rx_data), .rx_new(rx_new), .rx_error(uart_error),
		.UART_RX(UART_RX), .UART_TX(UART_TX)
	);

	spi_master u_spi (
		.clk(clk), .reset_n(reset_n),
		.div(spi_div), .cpol(cpol), .cpha(cpha), .bits16(bits16),
		.start(spi_start), .wdata(spi_wdata), .rdata(spi_rdata),
		.busy(busy_spi), .SEN(SEN), .SCLK(SCLK), .MOSI(MOSI), .MISO(MISO)
	);

endmodule

// File: spi/spi_master.sv
// SPI master
// Half SCLK period of div+1 clocks, CPOL/CPHA modes, 8 or 16 bit words
// Full duplex, MSB first, 8-bit words live in the low byte

`timescale 1ns/1ps

module spi_master (
	input  logic							clk,
	input  logic							reset_n,
	input  logic [comm_link_pkg::DIV_W-1:0]	div,
	input  logic							cpol,
	input  logic							cpha,
	input  logic							bits16,
	input  logic							start,
	input  logic [comm_link_pkg::SPI_W-1:0]	wdata,
	output logic [comm_link_pkg::SPI_W-1:0]	rdata,
	output logic							busy,
	output logic							SEN,
	output logic							SCLK,
	output logic							MOSI,
	input  logic							MISO
);
	import comm_link_pkg::*;

	logic [DIV_W-1:0]		half_cnt;
	logic [SPI_EDGE_W-1:0]	edges_left;
	logic					phase;		// SCLK away from idle level
	logic					wide;		// Width latched at start
	logic					mosi_q;
	logic [SPI_W-1:0]		load_word;	// MSB aligned
	logic [SPI_W-1:0]		tx_shift;
	logic [SPI_W-1:0]		rx_shift;
	logic					edge_now;
	logic					sample_now;
	logic					shift_now;
	logic					done;

	assign SCLK       = cpol ^ phase;
	assign MOSI       = mosi_q;
	assign load_word  = bits16 ? wdata : {wdata[7:0], 8'h00};
	assign edge_now   = busy && half_cnt == '0 && edges_left != '0;
	// Leading edge when phase is 0; cpha=0 samples there, cpha=1 shifts there
	assign sample_now = edge_now && (phase == cpha);
	assign shift_now  = edge_now && (phase != cpha);
	assign done       = busy && half_cnt == '0 && edges_left == '0;

	////////////////////
	// Clock and framing
	////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy       <= 1'b0;
			SEN        <= 1'b1;
			phase      <= 1'b0;
			half_cnt   <= '0;
			edges_left <= '0;
			wide       <= 1'b0;
			mosi_q     <= 1'b0;
		end else if (!busy) begin
			if (start) begin
				busy       <= 1'b1;
				SEN        <= 1'b0;
				half_cnt   <= div;
				wide       <= bits16;
				edges_left <= bits16 ? SPI_EDGE_W'(2 * SPI_W) : SPI_EDGE_W'(SPI_W);
				if (!cpha)
					mosi_q <= load_word[SPI_W-1];	// First bit before first edge
			end
		end else if (half_cnt != '0)
			half_cnt <= half_cnt - 1'b1;
		else if (done) begin
			busy <= 1'b0;	// Half period after the last edge
			SEN  <= 1'b1;
		end else begin
			phase      <= ~phase;
			edges_left <= edges_left - 1'b1;
			half_cnt   <= div;
			if (shift_now)
				mosi_q <= tx_shift[SPI_W-1];
		end
	end

	// Data shifters
	always_ff @(posedge clk) begin
		if (!busy && start)
			tx_shift <= cpha ? load_word : load_word << 1;
		else if (shift_now)
			tx_shift <= tx_shift << 1;
		if (sample_now)
			rx_shift <= {rx_shift[SPI_W-2:0], MISO};
		if (done)
			rdata <= wide ? rx_shift : {8'h00, rx_shift[7:0]};
	end

	a_sclk_idle: assert property (@(posedge clk) disable iff (!reset_n)
		SEN |-> SCLK == cpol)
		else $error("SCLK off idle level while deselected at %0t", $time);

endmodule

// File: uart/uart_link.sv
// UART link
// Transmitter and receiver sharing one bit period setting (div+1 clocks)
// 8 data bits LSB first, optional even/odd parity, one stop bit

`timescale 1ns/1ps

module uart_link (
	input  logic								clk,
	input  logic								reset_n,
	input  logic								enable,
	input  logic [comm_link_pkg::DIV_W-1:0]		div,
	input  logic								parity_en,
	input  logic								parity_odd,
	input  logic								tx_start,
	input  logic [comm_link_pkg::UART_W-1:0]	tx_data,
	output logic								tx_busy,
	input  logic								rx_ack,
	output logic [comm_link_pkg::UART_W-1:0]	rx_data,
	output logic								rx_new,
	output logic								rx_error,
	input  logic								UART_RX,
	output logic								UART_TX
);
	import comm_link_pkg::*;

	// Transmit side
	logic [DIV_W-1:0]		tx_cnt;
	logic [BITCNT_W-1:0]	tx_left;	// Bits still to send after the current one
	logic [UART_W+1:0]		tx_shift;	// Data, parity, stop
	logic					tx_par;
	logic					tx_line;

	// Receive side
	logic [1:0]				rx_sync;
	logic					rx_prev;
	logic					rx_active;
	logic					rx_first;	// In the start bit
	logic [DIV_W-1:0]		rx_cnt;
	logic [BITCNT_W-1:0]	rx_left;
	logic [UART_W+1:0]		rx_shift;
	logic [UART_W+1:0]		rx_frame;	// Shifter including the bit sampled now
	logic [UART_W-1:0]		rx_word;
	logic					rx_bad;
	logic					rx_sample;
	logic					rx_last;

	assign UART_TX = tx_line;
	assign tx_par  = ^tx_data ^ parity_odd;

	////////////////////
	// Transmitter
	////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			tx_busy <= 1'b0;
			tx_line <= 1'b1;	// Line idles high
			tx_cnt  <= '0;
			tx_left <= '0;
		end else if (!enable) begin
			tx_busy <= 1'b0;
			tx_line <= 1'b1;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy <= 1'b1;
				tx_line <= 1'b0;	// Start bit
				tx_cnt  <= div;
				tx_left <= parity_en ? BITCNT_W'(UART_W + 2) : BITCNT_W'(UART_W + 1);
			end
		end else if (tx_cnt != '0)
			tx_cnt <= tx_cnt - 1'b1;
		else if (tx_left == '0)
			tx_busy <= 1'b0;	// End of stop bit
		else begin
			tx_line <= tx_shift[0];
			tx_cnt  <= div;
			tx_left <= tx_left - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			tx_shift <= parity_en ? {1'b1, tx_par, tx_data} : {2'b11, tx_data};
		else if (tx_busy && tx_cnt == '0)
			tx_shift <= {1'b1, tx_shift[UART_W+1:1]};
	end

	////////////////////
	// Receiver
	////////////////////
	assign rx_frame  = {rx_sync[1], rx_shift[UART_W+1:1]};
	assign rx_word   = parity_en ? rx_frame[UART_W-1:0] : rx_frame[UART_W:1];
	assign rx_bad    = !rx_frame[UART_W+1] ||	// Missing stop
		(parity_en && ((^rx_word ^ rx_frame[UART_W]) != parity_odd));
	assign rx_sample = rx_active && !rx_first && rx_cnt == '0;
	assign rx_last   = rx_sample && rx_left == BITCNT_W'(1);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rx_sync   <= 2'b11;
			rx_prev   <= 1'b1;
			rx_active <= 1'b0;
			rx_first  <= 1'b0;
			rx_cnt    <= '0;
			rx_left   <= '0;
			rx_new    <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], UART_RX};
			rx_prev <= rx_sync[1];
			if (rx_ack)
				rx_new <= 1'b0;
			if (!enable)
				rx_active <= 1'b0;
			else if (!rx_active) begin
				if (rx_prev && !rx_sync[1]) begin	// Falling edge, start bit
					rx_active <= 1'b1;
					rx_first  <= 1'b1;
					rx_cnt    <= div >> 1;	// Land mid-bit
					rx_left   <= parity_en ? BITCNT_W'(UART_W + 2) : BITCNT_W'(UART_W + 1);
				end
			end else if (rx_cnt != '0)
				rx_cnt <= rx_cnt - 1'b1;
			else if (rx_first) begin
				rx_first  <= 1'b0;
				rx_cnt    <= div;
				rx_active <= !rx_sync[1];	// Glitch, no start bit
			end else begin
				rx_cnt  <= div;
				rx_left <= rx_left - 1'b1;
				if (rx_last) begin
					rx_active <= 1'b0;
					rx_new    <= 1'b1;	// Middle of stop bit
					rx_error  <= rx_bad;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_sample)
			rx_shift <= rx_frame;
		if (rx_last)
			rx_data <= rx_word;
	end

	a_tx_idle_high: assert property (@(posedge clk) disable iff (!reset_n)
		!tx_busy |-> UART_TX)
		else $error("UART_TX low while idle at %0t", $time);

endmodule

// File: nibble_ctrl/nibble_ctrl.sv
// Host nibble protocol controller
// Decodes the command nibble, holds link settings, assembles payload words
// and streams read-back words out MSB nibble first

`timescale 1ns/1ps

module nibble_ctrl (
	input  logic								clk,
	input  logic								reset_n,
	input  logic [3:0]							data_in,
	input  logic								data_en,
	output logic [3:0]							data_out,
	output logic [3:0]							data_op_en,
	// UART settings and data
	output logic								uart_enable,
	output logic [comm_link_pkg::DIV_W-1:0]		uart_div,
	output logic								parity_en,
	output logic								parity_odd,
	output logic								tx_start,
	output logic [comm_link_pkg::UART_W-1:0]	tx_data,
	input  logic [comm_link_pkg::UART_W-1:0]	rx_data,
	input  logic								rx_new,
	input  logic								rx_error,
	output logic								rx_ack,
	output logic								new_uart,
	// SPI settings and data
	output logic [comm_link_pkg::DIV_W-1:0]		spi_div,
	output logic								cpol,
	output logic								cpha,
	output logic								bits16,
	output logic								spi_start,
	output logic [comm_link_pkg::SPI_W-1:0]		spi_wdata,
	input  logic [comm_link_pkg::SPI_W-1:0]		spi_rdata
);
	import comm_cmd_pkg::*;
	import comm_link_pkg::*;

	ctrl_state_t		state;
	logic [1:0]			link_sel;	// Link of the running command
	logic [CNT_W-1:0]	cnt;		// Nibbles left after this one
	logic [SPI_W-1:0]	rd_word;	// Read-back shifter, next nibble on top
	logic [SPI_W-1:0]	wr_word;	// Payload assembly
	logic [1:0]			cmd_op;
	logic [1:0]			cmd_link;
	logic				link_ok;

	// Index of the last payload nibble for a link
	function automatic logic [CNT_W-1:0] last_nibble(input logic [1:0] lnk, input logic wide);
		if (lnk == LINK_SPI && wide)
			return CNT_W'(SPI16_NIBBLES - 1);
		if (lnk == LINK_SPI)
			return CNT_W'(SPI8_NIBBLES - 1);
		return CNT_W'(UART_NIBBLES - 1);
	endfunction

	assign cmd_op    = data_in[3:2];
	assign cmd_link  = data_in[1:0];
	assign tx_data   = wr_word[UART_W-1:0];
	assign spi_wdata = wr_word;			// SPI takes the low byte in 8-bit mode
	assign new_uart  = rx_new & ~rx_error;	// Good frames only

	always_comb begin
		case (cmd_link)
			LINK_UART, LINK_SPI: link_ok = 1'b1;
			LINK_I2C:            link_ok = 1'b0;	// No I2C link here
			default:             link_ok = 1'b0;
		endcase
	end

	////////////////////
	// Control FSM
	////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state       <= idle;
			link_sel    <= LINK_UART;
			cnt         <= '0;
			data_op_en  <= 4'h0;	// Pads as inputs
			tx_start    <= 1'b0;
			spi_start   <= 1'b0;
			rx_ack      <= 1'b0;
			uart_enable <= 1'b0;
			uart_div    <= '0;
			parity_en   <= 1'b0;
			parity_odd  <= 1'b0;
			spi_div     <= '0;
			cpol        <= 1'b0;
			cpha        <= 1'b0;
			bits16      <= 1'b0;
		end else begin
			// One-cycle pulses
			tx_start   <= 1'b0;
			spi_start  <= 1'b0;
			rx_ack     <= 1'b0;
			data_op_en <= 4'h0;
			case (state)
				idle: begin
					if (data_en && link_ok) begin
						link_sel <= cmd_link;
						case (cmd_op)
							CMD_READ: begin
								state <= read_out;
								cnt   <= last_nibble(cmd_link, bits16);
							end
							CMD_WRITE_NEW: begin
								state <= write_cfg;
								cnt   <= CNT_W'(CFG_NIBBLES - 1);
							end
							CMD_WRITE_OLD: begin
								state <= write_data;
								cnt   <= last_nibble(cmd_link, bits16);	// Stored width
							end
							default: state <= idle;
						endcase
					end
				end
				read_out: begin
					data_op_en <= 4'hF;
					cnt        <= cnt - 1'b1;
					if (cnt == '0) begin
						state  <= idle;
						rx_ack <= (link_sel == LINK_UART);	// Frame consumed
					end
				end
				write_cfg: begin
					cnt <= cnt - 1'b1;
					if (!data_en)
						state <= idle;	// Host gave up
					else if (cnt != '0) begin
						// Divider, high nibble first
						if (link_sel == LINK_UART)
							uart_div <= {uart_div[DIV_W-5:0], data_in};
						else
							spi_div <= {spi_div[DIV_W-5:0], data_in};
					end else if (link_sel == LINK_UART) begin
						uart_enable <= data_in[UART_EN_BIT];
						parity_en   <= data_in[UART_PAR_EN_BIT];
						parity_odd  <= data_in[UART_PAR_ODD_BIT];
						state <= data_in[UART_SEND_BIT] ? write_data : idle;
						cnt   <= last_nibble(LINK_UART, 1'b0);
					end else begin
						cpol   <= data_in[SPI_CPOL_BIT];
						cpha   <= data_in[SPI_CPHA_BIT];
						bits16 <= data_in[SPI_BITS16_BIT];
						state  <= data_in[SPI_START_BIT] ? write_data : idle;
						cnt    <= last_nibble(LINK_SPI, data_in[SPI_BITS16_BIT]);
					end
				end
				write_data: begin
					cnt <= cnt - 1'b1;
					if (!data_en)
						state <= idle;
					else if (cnt == '0) begin
						state     <= idle;
						tx_start  <= (link_sel == LINK_UART);	// Seen by link next edge
						spi_start <= (link_sel == LINK_SPI);
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Read and write shifters
	always_ff @(posedge clk) begin
		if (state == idle && data_en) begin
			// Snapshot at the command edge
			if (cmd_link == LINK_SPI && bits16)
				rd_word <= spi_rdata;
			else if (cmd_link == LINK_SPI)
				rd_word <= {spi_rdata[7:0], 8'h00};
			else
				rd_word <= {rx_data, 8'h00};
		end else if (state == read_out) begin
			data_out <= rd_word[SPI_W-1 -: 4];
			rd_word  <= rd_word << 4;
		end
		if (state == write_data && data_en)
			wr_word <= {wr_word[SPI_W-5:0], data_in};
	end

	a_op_en_whole: assert property (@(posedge clk) disable iff (!reset_n)
		data_op_en == 4'h0 || data_op_en == 4'hF)
		else $error("data_op_en split %b at %0t", data_op_en, $time);

	a_start_single: assert property (@(posedge clk) disable iff (!reset_n)
		(tx_start || spi_start) |=> !(tx_start || spi_start))
		else $error("start pulse held in state %s at %0t", state.name(), $time);

endmodule

// File: common/comm_link_pkg.sv
// Serial link definitions
// Word widths, counter widths and settings flag positions for UART and SPI
package comm_link_pkg;

	localparam int DIV_W  = 8;		// Bit period / half SCLK period setting
	localparam int UART_W = 8;		// UART character
	localparam int SPI_W  = 16;		// Widest SPI word

	localparam int BITCNT_W   = 4;	// UART bits per frame, up to 10 after start
	localparam int SPI_EDGE_W = 6;	// SCLK edges per transfer, up to 32

	////////////////////
	// UART flag nibble
	////////////////////
	localparam int UART_EN_BIT      = 3;
	localparam int UART_SEND_BIT    = 2;	// Payload follows
	localparam int UART_PAR_EN_BIT  = 1;
	localparam int UART_PAR_ODD_BIT = 0;

	////////////////////
	// SPI flag nibble
	////////////////////
	localparam int SPI_CPOL_BIT   = 3;
	localparam int SPI_CPHA_BIT   = 2;
	localparam int SPI_BITS16_BIT = 1;
	localparam int SPI_START_BIT  = 0;	// Payload follows

endpackage

// File: common/comm_cmd_pkg.sv
// Host command definitions for the nibble port
// Command nibble encoding, controller states and per-link nibble counts
package comm_cmd_pkg;

	////////////////////
	// Command nibble {op[1:0], link[1:0]}
	////////////////////

	// Operation, upper half
	localparam logic [1:0] CMD_READ      = 2'b00;
	localparam logic [1:0] CMD_WRITE_OLD = 2'b10;	// Reuse stored settings
	localparam logic [1:0] CMD_WRITE_NEW = 2'b11;	// Settings nibbles first

	// Target link, lower half
	localparam logic [1:0] LINK_UART = 2'b00;
	localparam logic [1:0] LINK_SPI  = 2'b01;
	localparam logic [1:0] LINK_I2C  = 2'b10;	// Decoded, no link behind it

	////////////////////
	// Nibble counts
	////////////////////

	// Divider high, divider low, flags
	localparam int CFG_NIBBLES = 3;

	// Payload and read-back lengths
	localparam int UART_NIBBLES  = 2;
	localparam int SPI8_NIBBLES  = 2;
	localparam int SPI16_NIBBLES = 4;

	// Down counter over the longest sequence
	localparam int CNT_W = 2;

	// Controller FSM
	typedef enum logic [1:0] {
		idle,		// Waiting for a command nibble
		read_out,	// Driving read-back nibbles
		write_cfg,	// Taking divider and flag nibbles
		write_data	// Taking payload nibbles
	} ctrl_state_t;

endpackage
